//--- common/cache_defs.svh
/* Cache host sizing macros
   Line, tag, key, load and LFSR widths plus the reset seeds */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Line store geometry
`define CACHE_LINES     8
`define DATA_WIDTH      16
`define TAG_WIDTH       4
`define INDEX_WIDTH     6
`define LINE_SEL_WIDTH  3

// Key and payload widths
`define KEY_WIDTH       128
`define LOAD_WIDTH      64
`define LFSR_WIDTH      20

// Reset seeds
`define KEY_SEED        128'hCAFEBABE_DEADBEEF_CAFEBABE_DEADBEEF
`define LFSR_SEED       20'b1001_1001_1001_1001_1001

`endif

//--- common/cache_pkg.sv
/* Cache host types
   Width typedefs and the request controller states */
`include "cache_defs.svh"

package cache_pkg;

    // One cache line and its address parts
    typedef logic [`DATA_WIDTH-1:0]     data_t;
    typedef logic [`TAG_WIDTH-1:0]      tag_t;
    typedef logic [`INDEX_WIDTH-1:0]    index_t;   // Full request index, may exceed line count
    typedef logic [`LINE_SEL_WIDTH-1:0] line_sel_t;

    // Key register and payload
    typedef logic [`KEY_WIDTH-1:0]      key_t;
    typedef logic [`LOAD_WIDTH-1:0]     load_t;
    typedef logic [`LFSR_WIDTH-1:0]     lfsr_t;

    // Request controller
    typedef enum logic [1:0] {
        IDLE     = 2'd0,   // Waiting for a strobe
        ACCESS   = 2'd1,   // Store write or read capture
        COMPLETE = 2'd2    // Ready pulse is raised on leaving
    } host_state_e;

endpackage

//--- cache_host/cache_store.sv
/* Line store for the cache host
   Eight data, tag and valid entries with one write port and a tag compare */
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_store
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  line_sel_t line_sel,
    input  tag_t      wr_tag,
    input  data_t     wr_data,
    input  index_t    lookup_index,
    input  tag_t      lookup_tag,
    output logic      hit,
    output data_t     line_data
);

    data_t                   data_mem [`CACHE_LINES];
    tag_t                    tag_mem  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid;

    line_sel_t lookup_sel;
    logic      in_range;

    // Entries are cleared along with the valid bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                data_mem[i] <= '0;
                tag_mem[i]  <= '0;
            end
        end else if (wr_en) begin
            data_mem[line_sel] <= wr_data;
            tag_mem[line_sel]  <= wr_tag;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[line_sel] <= 1'b1;
        end
    end

    assign lookup_sel = lookup_index[`LINE_SEL_WIDTH-1:0];

    // Reads beyond the last line never hit
    assign in_range = (lookup_index < index_t'(`CACHE_LINES));

    assign hit = in_range && valid[lookup_sel] && (tag_mem[lookup_sel] == lookup_tag);

    assign line_data = data_mem[line_sel];   // Latched selector

endmodule

//--- trojan/trojan0.sv
/* Payload block trojan0
   LFSR stepped per access, mixed with the host key into a 64-bit load */
`timescale 1ns/10ps
`include "cache_defs.svh"

module trojan0
    import cache_pkg::*;
#(
    parameter lfsr_t INIT_VALUE = `LFSR_SEED
) (
    input  logic  clk,
    input  logic  rst,
    input  key_t  key,
    input  logic  step,
    output load_t load
);

    lfsr_t lfsr;
    logic  feedback;

    // Taps at bits 19 and 16
    assign feedback = lfsr[`LFSR_WIDTH-1] ^ lfsr[`LFSR_WIDTH-4];

    // Holds between accesses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= INIT_VALUE;
        end else if (step) begin
            lfsr <= {lfsr[`LFSR_WIDTH-2:0], feedback};
        end
    end

    // Low key half against the zero-extended LFSR
    assign load = key[`LOAD_WIDTH-1:0] ^ {{(`LOAD_WIDTH-`LFSR_WIDTH){1'b0}}, lfsr};

endmodule

//--- cache_host/cache_host.sv
/* Direct-mapped cache host with request controller and key mixer
   Serves single reads and writes, masks read hits with the payload load */
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_host
    import cache_pkg::*;
#(
    parameter key_t  KEY_INIT        = `KEY_SEED,
    parameter lfsr_t TROJ_INIT_VALUE = `LFSR_SEED
) (
    input  logic   clk,
    input  logic   rst,
    input  tag_t   addr_tag,
    input  index_t addr_index,
    input  data_t  write_data,
    input  logic   cache_read,
    input  logic   cache_write,
    output data_t  read_data,
    output logic   cache_hit,
    output logic   cache_ready
);

    // Byte of the key that takes the index
    localparam int MIX_BITS = 8;

    host_state_e state;
    host_state_e state_next;

    logic      accept;       // Request taken this cycle
    logic      req_write;    // Latched op, write has priority
    line_sel_t line_sel;
    logic      wr_en;

    key_t      key;
    load_t     load;

    logic      store_hit;
    data_t     line_data;
    data_t     masked_data;

    // Only in IDLE and never while the ready pulse is out
    assign accept = (state == IDLE) && !cache_ready && (cache_read || cache_write);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = ACCESS;
                end
            end
            ACCESS:   state_next = COMPLETE;
            COMPLETE: state_next = IDLE;
            default:  state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request fields captured at accept
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_sel  <= '0;
            req_write <= 1'b0;
        end else if (accept) begin
            line_sel  <= addr_index[`LINE_SEL_WIDTH-1:0];  // Index 8+ wraps for writes
            req_write <= cache_write;                      // Both strobes act as write
        end
    end

    // Store write happens while leaving ACCESS
    assign wr_en = (state == ACCESS) && req_write;

    /* Key rotates left by one byte on every accepted request,
       the byte moved to the bottom is mixed with the request index */
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key <= KEY_INIT;
        end else if (accept) begin
            key <= {key[`KEY_WIDTH-MIX_BITS-1:0],
                    key[`KEY_WIDTH-1 -: MIX_BITS] ^
                    {{(MIX_BITS-`INDEX_WIDTH){1'b0}}, addr_index}};
        end
    end

    // Hit data gets the low load bits, misses read as zero
    assign masked_data = store_hit ? (line_data ^ load[`DATA_WIDTH-1:0]) : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_data <= '0;
        end else if ((state == ACCESS) && !req_write) begin
            read_data <= masked_data;
        end
    end

    // One cycle pulse, the cycle after COMPLETE
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cache_ready <= 1'b0;
        end else begin
            cache_ready <= (state == COMPLETE);
        end
    end

    assign cache_hit = store_hit;   // Straight from current inputs

    cache_store u_store (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (wr_en),
        .line_sel     (line_sel),
        .wr_tag       (addr_tag),
        .wr_data      (write_data),
        .lookup_index (addr_index),
        .lookup_tag   (addr_tag),
        .hit          (store_hit),
        .line_data    (line_data)
    );

    trojan0 #(
        .INIT_VALUE (TROJ_INIT_VALUE)
    ) u_trojan (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .step (accept),   // LFSR steps with the key
        .load (load)
    );

endmodule

//--- sim/cache_ref_model.svh
/* Reference model of the cache host
   Lines, key register and payload LFSR, stepped once per request */
`ifndef CACHE_REF_MODEL_SVH
`define CACHE_REF_MODEL_SVH

data_t ref_data  [`CACHE_LINES];
tag_t  ref_tag   [`CACHE_LINES];
logic  ref_valid [`CACHE_LINES];
key_t  ref_key;
lfsr_t ref_lfsr;

logic  exp_hit;          // Hit seen during the ready pulse
data_t exp_read_data;    // Holds across writes

task automatic reset_model();
    int k;
    for (k = 0; k < `CACHE_LINES; k++) begin
        ref_data[k]  = '0;
        ref_tag[k]   = '0;
        ref_valid[k] = 1'b0;
    end
    ref_key       = `KEY_SEED;
    ref_lfsr      = `LFSR_SEED;
    exp_hit       = 1'b0;
    exp_read_data = '0;
endtask

// Key moves up a byte, old top byte comes back at the bottom mixed with the index
task automatic advance_key_lfsr(input index_t index);
    logic [7:0] top;
    logic       fb;
    top      = ref_key[127:120];
    fb       = ref_lfsr[19] ^ ref_lfsr[16];
    ref_key  = {ref_key[119:0], top ^ {2'b00, index}};
    ref_lfsr = {ref_lfsr[18:0], fb};
endtask

function automatic load_t payload_load();
    return ref_key[63:0] ^ {44'd0, ref_lfsr};
endfunction

task automatic apply_to_model(input logic [1:0] op, input tag_t tag,
                              input index_t index, input data_t data);
    line_sel_t sel;
    load_t     load;
    sel = index[2:0];      // Writes wrap on the low bits
    advance_key_lfsr(index);
    load = payload_load();
    if (op[1]) begin       // Write wins over read
        ref_data[sel]  = data;
        ref_tag[sel]   = tag;
        ref_valid[sel] = 1'b1;
    end
    exp_hit = (index < 8) && ref_valid[sel] && (ref_tag[sel] == tag);
    if (!op[1]) begin
        exp_read_data = exp_hit ? (ref_data[sel] ^ load[15:0]) : '0;
    end
endtask

`endif

//--- sim/cache_host_tb.sv
/* Testbench for the cache host
   Table of reads and writes checked against a model of lines, key and LFSR */
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_host_tb
    import cache_pkg::*;
();

    localparam logic [1:0] OP_READ  = 2'b01;
    localparam logic [1:0] OP_WRITE = 2'b10;
    localparam logic [1:0] OP_BOTH  = 2'b11;
    localparam int MAX_ENTRIES   = 48;
    localparam int READY_TIMEOUT = 10;
    localparam int READY_LATENCY = 4;   // Falling edges from the drive edge to the pulse

    logic   clk;
    logic   rst;
    tag_t   addr_tag;
    index_t addr_index;
    data_t  write_data;
    logic   cache_read;
    logic   cache_write;
    data_t  read_data;
    logic   cache_hit;
    logic   cache_ready;

    // Stimulus table
    logic [1:0] op_tab   [MAX_ENTRIES];
    tag_t       tag_tab  [MAX_ENTRIES];
    index_t     idx_tab  [MAX_ENTRIES];
    data_t      data_tab [MAX_ENTRIES];
    int         num_entries = 0;

    integer seed = 63;

    `include "cache_ref_model.svh"

    cache_host DUT (
        .clk         (clk),
        .rst         (rst),
        .addr_tag    (addr_tag),
        .addr_index  (addr_index),
        .write_data  (write_data),
        .cache_read  (cache_read),
        .cache_write (cache_write),
        .read_data   (read_data),
        .cache_hit   (cache_hit),
        .cache_ready (cache_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at first error");
        end
    endtask

    function automatic data_t next_random_data();
        return data_t'($random(seed));
    endfunction

    task automatic add_entry(input logic [1:0] op, input tag_t tag,
                             input index_t index, input data_t data);
        op_tab[num_entries]   = op;
        tag_tab[num_entries]  = tag;
        idx_tab[num_entries]  = index;
        data_tab[num_entries] = data;
        num_entries++;
    endtask

    task automatic build_table();
        int k;
        // Nothing valid yet
        for (k = 0; k < 8; k++) begin
            add_entry(OP_READ, 4'h0, index_t'(k), '0);
        end
        add_entry(OP_READ, 4'h0, 6'd8, '0);
        add_entry(OP_READ, 4'hF, 6'd63, '0);
        // Fill a few lines then read them back
        add_entry(OP_WRITE, 4'h3, 6'd0, next_random_data());
        add_entry(OP_WRITE, 4'h5, 6'd2, next_random_data());
        add_entry(OP_WRITE, 4'hA, 6'd7, next_random_data());
        add_entry(OP_WRITE, 4'h1, 6'd4, 16'h1234);
        add_entry(OP_READ,  4'h3, 6'd0, '0);
        add_entry(OP_READ,  4'h5, 6'd2, '0);
        add_entry(OP_READ,  4'hA, 6'd7, '0);
        add_entry(OP_READ,  4'h1, 6'd4, '0);
        // Misses: wrong tag, empty line, index past the last line
        add_entry(OP_READ,  4'h4, 6'd0, '0);
        add_entry(OP_READ,  4'h0, 6'd3, '0);
        add_entry(OP_READ,  4'h3, 6'd8, '0);
        add_entry(OP_READ,  4'h3, 6'd40, '0);
        // Index 9 lands in line 1
        add_entry(OP_WRITE, 4'h6, 6'd9, next_random_data());
        add_entry(OP_READ,  4'h6, 6'd1, '0);
        add_entry(OP_READ,  4'h6, 6'd9, '0);
        // Both strobes high
        add_entry(OP_BOTH,  4'h2, 6'd5, 16'hBEEF);
        add_entry(OP_READ,  4'h2, 6'd5, '0);
        add_entry(OP_BOTH,  4'h2, 6'd5, next_random_data());
        add_entry(OP_READ,  4'h2, 6'd5, '0);
        add_entry(OP_WRITE, 4'h3, 6'd0, next_random_data());
        add_entry(OP_READ,  4'h3, 6'd0, '0);
        add_entry(OP_READ,  4'hA, 6'd7, '0);
    endtask

    // One request, strobes held through the ready pulse
    task automatic run_request(input int i);
        int   cycles;
        logic seen;
        @(posedge clk);
        addr_tag    <= tag_tab[i];
        addr_index  <= idx_tab[i];
        write_data  <= data_tab[i];
        cache_read  <= op_tab[i][0];
        cache_write <= op_tab[i][1];
        apply_to_model(op_tab[i], tag_tab[i], idx_tab[i], data_tab[i]);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = cache_ready;
        end
        if (!seen) begin
            $display("Timeout: cache_ready did not rise for request %0d", i);
            $display("CHECKS FAILED");
            $fatal(1, "No ready pulse");
        end
        check_value("ready_latency", cycles, READY_LATENCY);
        check_value("read_data", read_data, exp_read_data);
        check_value("cache_hit", cache_hit, exp_hit);
        @(posedge clk);                 // Pulse falls on this edge
        cache_read  <= 1'b0;
        cache_write <= 1'b0;
        @(negedge clk);
        check_value("cache_ready", cache_ready, 1'b0);
    endtask

    initial begin
        rst         = 1'b1;
        addr_tag    = '0;
        addr_index  = '0;
        write_data  = '0;
        cache_read  = 1'b0;
        cache_write = 1'b0;
        build_table();
        reset_model();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("cache_ready", cache_ready, 1'b0);
        check_value("read_data", read_data, 16'h0000);
        for (int i = 0; i < num_entries; i++) begin
            run_request(i);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- src.f
+incdir+common
+incdir+sim
common/cache_pkg.sv
cache_host/cache_store.sv
trojan/trojan0.sv
cache_host/cache_host.sv
sim/cache_host_tb.sv
